//--- hw/pov_defs.svh
// Display geometry, address width, column timing and SPI synchroniser depth
`ifndef POV_DEFS_SVH
`define POV_DEFS_SVH

// LEDs in one column and columns in one revolution
`define POV_LEDS 8
`define POV_COLS 16

// Pixel address is column * LEDs + led
`define POV_ADDR_W 7

// Clock cycles between two column ticks
`define POV_COL_PERIOD 256

`define POV_SPI_SYNC 2

`endif

//--- hw/pov_pkg.sv
// Pixel, pixel write, column and SPI byte types with the command opcodes
`include "pov_defs.svh"

package pov_pkg;

   typedef struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
   } pixel_t;

   typedef struct packed {
      logic                   valid;
      logic [`POV_ADDR_W-1:0] addr;
      pixel_t                 px;
   } pix_wr_t;

   // LED 0 sits in the low entry of px
   typedef struct packed {
      logic                          valid;
      logic [$clog2(`POV_COLS)-1:0]  idx;
      pixel_t [`POV_LEDS-1:0]        px;
   } column_t;

   typedef struct packed {
      logic       valid;
      logic       first;
      logic [7:0] data;
   } spi_byte_t;

   typedef enum logic [7:0] {
      CMD_WR_PIXEL  = 8'h01,
      CMD_SET_CTRL  = 8'h02,
      CMD_RD_STATUS = 8'h03
   } cmd_e;

endpackage

//--- hw/spi_slave.sv
// SPI mode 0 slave with pin synchronisers, byte receiver and reply shifter
`include "pov_defs.svh"

module spi_slave (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               spi_sclk,
   input  logic               spi_cs_n,
   input  logic               spi_mosi,
   output logic               spi_miso,
   input  logic [7:0]         tx_byte,
   output pov_pkg::spi_byte_t rx
);

   // One {sclk, cs_n, mosi} triple per synchroniser stage
   logic [`POV_SPI_SYNC-1:0][2:0] pin_sync;
   logic       sclk_s;
   logic       cs_n_s;
   logic       mosi_s;
   logic       sclk_prev;
   logic       sclk_rise;
   logic       sclk_fall;
   logic [2:0] bit_cnt;
   logic [7:0] rx_sr;
   logic [7:0] rx_data;
   logic       rx_valid;
   logic       rx_first;
   logic       first_pend;
   logic [7:0] tx_sr;
   logic       load_reply;

   assign {sclk_s, cs_n_s, mosi_s} = pin_sync[`POV_SPI_SYNC-1];
   assign sclk_rise = sclk_s & ~sclk_prev;
   assign sclk_fall = ~sclk_s & sclk_prev;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pin_sync   <= {`POV_SPI_SYNC{3'b010}};
         sclk_prev  <= 1'b0;
         bit_cnt    <= 3'd0;
         first_pend <= 1'b1;
         rx_valid   <= 1'b0;
         rx_first   <= 1'b0;
      end else begin
         pin_sync  <= {pin_sync[`POV_SPI_SYNC-2:0], {spi_sclk, spi_cs_n, spi_mosi}};
         sclk_prev <= sclk_s;
         rx_valid  <= 1'b0;
         if (cs_n_s) begin
            bit_cnt    <= 3'd0;
            first_pend <= 1'b1;
         end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
               rx_valid   <= 1'b1;
               rx_first   <= first_pend;
               first_pend <= 1'b0;
            end
         end
      end
   end

   // Receive shifter, MSB first
   always_ff @(posedge clk) begin
      if (!cs_n_s && sclk_rise) begin
         rx_sr <= {rx_sr[6:0], mosi_s};
         if (bit_cnt == 3'd7)
            rx_data <= {rx_sr[6:0], mosi_s};
      end
   end

   // Reply byte is taken one cycle after rx valid, once the decoder has updated it.
   // No shift on the falling edge that closes a byte, so the new MSB stays on miso
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_sr      <= 8'h00;
         load_reply <= 1'b0;
      end else begin
         load_reply <= rx_valid;
         if (cs_n_s)
            tx_sr <= 8'h00;
         else if (load_reply)
            tx_sr <= tx_byte;
         else if (sclk_fall && bit_cnt != 3'd0)
            tx_sr <= {tx_sr[6:0], 1'b0};
      end
   end

   assign spi_miso = ~spi_cs_n & tx_sr[7];
   assign rx       = '{valid: rx_valid, first: rx_first, data: rx_data};

endmodule

//--- hw/spi_cmd_decoder.sv
// Command frame decoder for pixel writes, display enable and status readback
`include "pov_defs.svh"

module spi_cmd_decoder (
   input  logic               clk,
   input  logic               rst_n,
   input  pov_pkg::spi_byte_t rx,
   output logic [7:0]         tx_byte,
   input  logic [15:0]        rev_count,
   output pov_pkg::pix_wr_t   pix_wr,
   output logic               disp_en
);

   pov_pkg::cmd_e          op;
   logic                   active;
   logic [2:0]             byte_idx;
   logic [7:0]             stat_lo;
   logic                   wr_valid;
   logic [`POV_ADDR_W-1:0] wr_addr;
   pov_pkg::pixel_t        wr_px;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         op       <= pov_pkg::CMD_WR_PIXEL;
         active   <= 1'b0;
         byte_idx <= 3'd0;
         tx_byte  <= 8'h00;
         disp_en  <= 1'b0;
         wr_valid <= 1'b0;
      end else begin
         wr_valid <= 1'b0;
         if (rx.valid) begin
            tx_byte <= 8'h00;
            if (rx.first) begin
               op       <= pov_pkg::cmd_e'(rx.data);
               byte_idx <= 3'd1;
               case (rx.data)
                  pov_pkg::CMD_WR_PIXEL,
                  pov_pkg::CMD_SET_CTRL: active <= 1'b1;
                  pov_pkg::CMD_RD_STATUS: begin
                     active  <= 1'b1;
                     tx_byte <= rev_count[15:8];
                  end
                  // Unknown opcode, rest of the frame is ignored
                  default: active <= 1'b0;
               endcase
            end else if (active) begin
               byte_idx <= byte_idx + 3'd1;
               case (op)
                  pov_pkg::CMD_WR_PIXEL: begin
                     if (byte_idx == 3'd4) begin
                        wr_valid <= 1'b1;
                        active   <= 1'b0;
                     end
                  end
                  pov_pkg::CMD_SET_CTRL: begin
                     disp_en <= rx.data[0];
                     active  <= 1'b0;
                  end
                  pov_pkg::CMD_RD_STATUS: begin
                     if (byte_idx == 3'd1)
                        tx_byte <= stat_lo;
                     else
                        active <= 1'b0;
                  end
                  default: active <= 1'b0;
               endcase
            end
         end
      end
   end

   // Low status byte is frozen with the high one when the opcode arrives
   always_ff @(posedge clk) begin
      if (rx.valid && rx.first)
         stat_lo <= rev_count[7:0];
      if (rx.valid && !rx.first && active && op == pov_pkg::CMD_WR_PIXEL) begin
         if (byte_idx == 3'd1)
            wr_addr <= rx.data[`POV_ADDR_W-1:0];
         else if (byte_idx == 3'd2)
            wr_px.r <= rx.data;
         else if (byte_idx == 3'd3)
            wr_px.g <= rx.data;
         else if (byte_idx == 3'd4)
            wr_px.b <= rx.data;
      end
   end

   assign pix_wr = '{valid: wr_valid, addr: wr_addr, px: wr_px};

endmodule

//--- hw/image_ram.sv
// Simple dual-port pixel memory with registered read
`include "pov_defs.svh"

module image_ram (
   input  logic                   clk,
   input  pov_pkg::pix_wr_t       wr,
   input  logic [`POV_ADDR_W-1:0] rd_addr,
   output pov_pkg::pixel_t        rd_data
);

   pov_pkg::pixel_t mem [1 << `POV_ADDR_W];

   // Read before write, a colliding read sees the old pixel
   always_ff @(posedge clk) begin
      if (wr.valid)
         mem[wr.addr] <= wr.px;
      rd_data <= mem[rd_addr];
   end

endmodule

//--- hw/column_scanner.sv
// Column and revolution counters with the per-tick column read sequencer
`include "pov_defs.svh"

module column_scanner (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   col_tick,
   input  logic                   disp_en,
   output logic [`POV_ADDR_W-1:0] rd_addr,
   input  pov_pkg::pixel_t        rd_data,
   output pov_pkg::column_t       col,
   output logic [15:0]            rev_count
);

   localparam int COL_W = $clog2(`POV_COLS);
   localparam int LED_W = $clog2(`POV_LEDS);

   logic [COL_W-1:0]                col_idx;
   logic [COL_W-1:0]                scan_col;
   logic                            busy;
   logic [LED_W-1:0]                rd_cnt;
   logic                            start;
   logic                            rd_issue;
   logic [LED_W-1:0]                rd_led;
   logic                            rd_pend;
   logic [LED_W-1:0]                led_q;
   logic                            col_valid;
   pov_pkg::pixel_t [`POV_LEDS-1:0] col_px;

   // First read goes out in the tick cycle itself
   assign start    = col_tick & disp_en;
   assign rd_issue = start | busy;
   assign rd_led   = start ? '0 : rd_cnt;
   assign rd_addr  = {start ? col_idx : scan_col, rd_led};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         col_idx   <= '0;
         scan_col  <= '0;
         rev_count <= 16'd0;
         busy      <= 1'b0;
         rd_cnt    <= '0;
         rd_pend   <= 1'b0;
         led_q     <= '0;
         col_valid <= 1'b0;
      end else begin
         rd_pend   <= rd_issue;
         led_q     <= rd_led;
         col_valid <= rd_pend && (led_q == LED_W'(`POV_LEDS - 1));
         // Rotation keeps counting with the display off
         if (col_tick) begin
            if (col_idx == COL_W'(`POV_COLS - 1)) begin
               col_idx   <= '0;
               rev_count <= rev_count + 16'd1;
            end else begin
               col_idx <= col_idx + 1'b1;
            end
         end
         if (start) begin
            scan_col <= col_idx;
            busy     <= 1'b1;
            rd_cnt   <= LED_W'(1);
         end else if (busy) begin
            rd_cnt <= rd_cnt + 1'b1;
            if (rd_cnt == LED_W'(`POV_LEDS - 1))
               busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_pend)
         col_px[led_q] <= rd_data;
   end

   assign col = '{valid: col_valid, idx: scan_col, px: col_px};

endmodule

//--- hw/led_driver_ctrl.sv
// Three-lane LED driver serialiser with shift clock, latch and column select
`include "pov_defs.svh"

module led_driver_ctrl (
   input  logic             clk,
   input  logic             rst_n,
   input  pov_pkg::column_t col,
   output logic             drv_sclk,
   output logic             drv_lat,
   output logic [2:0]       drv_sin,
   output logic [3:0]       col_sel
);

   localparam int LANE_W = `POV_LEDS * 8;
   localparam int CNT_W  = $clog2(LANE_W);

   logic [2:0][LANE_W-1:0] lanes;
   logic [2:0][LANE_W-1:0] sr;
   logic                   busy;
   logic                   phase;
   logic [CNT_W-1:0]       bit_cnt;
   logic [3:0]             idx_q;

   // Lane 0 red, 1 green, 2 blue. LED 0 first, MSB first within each byte
   always_comb begin
      for (int i = 0; i < `POV_LEDS; i++) begin
         lanes[0][LANE_W-1-8*i -: 8] = col.px[i].r;
         lanes[1][LANE_W-1-8*i -: 8] = col.px[i].g;
         lanes[2][LANE_W-1-8*i -: 8] = col.px[i].b;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy     <= 1'b0;
         phase    <= 1'b0;
         bit_cnt  <= '0;
         drv_sclk <= 1'b0;
         drv_lat  <= 1'b0;
         drv_sin  <= 3'b000;
         col_sel  <= 4'd0;
      end else begin
         drv_lat <= 1'b0;
         if (!busy) begin
            // A column arriving mid-shift is simply dropped
            if (col.valid) begin
               busy     <= 1'b1;
               phase    <= 1'b0;
               bit_cnt  <= '0;
               drv_sclk <= 1'b0;
               drv_sin  <= {lanes[2][LANE_W-1], lanes[1][LANE_W-1], lanes[0][LANE_W-1]};
            end
         end else if (!phase) begin
            phase    <= 1'b1;
            drv_sclk <= 1'b1;
         end else begin
            phase    <= 1'b0;
            drv_sclk <= 1'b0;
            if (bit_cnt == CNT_W'(LANE_W - 1)) begin
               busy    <= 1'b0;
               drv_lat <= 1'b1;
               col_sel <= idx_q;
               drv_sin <= 3'b000;
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
               drv_sin <= {sr[2][LANE_W-2], sr[1][LANE_W-2], sr[0][LANE_W-2]};
            end
         end
      end
   end

   // Shift on the high half of each bit
   always_ff @(posedge clk) begin
      if (!busy && col.valid) begin
         sr    <= lanes;
         idx_q <= col.idx;
      end else if (busy && phase) begin
         for (int l = 0; l < 3; l++)
            sr[l] <= {sr[l][LANE_W-2:0], 1'b0};
      end
   end

endmodule

//--- hw/rotation_emulator.sv
// Column tick generator standing in for the Hall sensor
`include "pov_defs.svh"

module rotation_emulator (
   input  logic clk,
   input  logic rst_n,
   output logic col_tick
);

   localparam int CNT_W = $clog2(`POV_COL_PERIOD);

   logic [CNT_W-1:0] cnt;

   // Tick lands in the cycle after the counter's last value
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt      <= '0;
         col_tick <= 1'b0;
      end else begin
         col_tick <= (cnt == CNT_W'(`POV_COL_PERIOD - 1));
         if (cnt == CNT_W'(`POV_COL_PERIOD - 1))
            cnt <= '0;
         else
            cnt <= cnt + 1'b1;
      end
   end

endmodule

//--- hw/pov_top.sv
// POV display top level with SPI control, image memory, scanner and LED driver
`include "pov_defs.svh"

module pov_top (
   input  logic       clk,
   input  logic       rst_n,
   // SPI
   input  logic       spi_sclk,
   input  logic       spi_cs_n,
   input  logic       spi_mosi,
   output logic       spi_miso,
   // LED drivers
   output logic       drv_sclk,
   output logic       drv_lat,
   output logic [2:0] drv_sin,
   output logic [3:0] col_sel
);

   pov_pkg::spi_byte_t     rx;
   logic [7:0]             tx_byte;
   pov_pkg::pix_wr_t       pix_wr;
   logic                   disp_en;
   logic [15:0]            rev_count;
   logic                   col_tick;
   logic [`POV_ADDR_W-1:0] rd_addr;
   pov_pkg::pixel_t        rd_data;
   pov_pkg::column_t       col;

   spi_slave i_spi_slave (
      .clk      (clk),
      .rst_n    (rst_n),
      .spi_sclk (spi_sclk),
      .spi_cs_n (spi_cs_n),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso),
      .tx_byte  (tx_byte),
      .rx       (rx)
   );

   spi_cmd_decoder i_spi_cmd_decoder (
      .clk       (clk),
      .rst_n     (rst_n),
      .rx        (rx),
      .tx_byte   (tx_byte),
      .rev_count (rev_count),
      .pix_wr    (pix_wr),
      .disp_en   (disp_en)
   );

   image_ram i_image_ram (
      .clk     (clk),
      .wr      (pix_wr),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   // Hall sensor stand-in
   rotation_emulator i_rotation_emulator (
      .clk      (clk),
      .rst_n    (rst_n),
      .col_tick (col_tick)
   );

   column_scanner i_column_scanner (
      .clk       (clk),
      .rst_n     (rst_n),
      .col_tick  (col_tick),
      .disp_en   (disp_en),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .col       (col),
      .rev_count (rev_count)
   );

   led_driver_ctrl i_led_driver_ctrl (
      .clk      (clk),
      .rst_n    (rst_n),
      .col      (col),
      .drv_sclk (drv_sclk),
      .drv_lat  (drv_lat),
      .drv_sin  (drv_sin),
      .col_sel  (col_sel)
   );

endmodule

//--- verification/tb_pov_top.sv
// Testbench for pov_top with SPI host, LED lane sampler and a table of tests
`include "pov_defs.svh"

module tb_pov_top;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int COL_PERIOD = `POV_COL_PERIOD;
   localparam logic [2:0] K_IDLE    = 3'd0;
   localparam logic [2:0] K_FILL    = 3'd1;
   localparam logic [2:0] K_REWRITE = 3'd2;
   localparam logic [2:0] K_STATUS  = 3'd3;
   localparam logic [2:0] K_DISABLE = 3'd4;
   localparam logic [2:0] K_UNKNOWN = 3'd5;

   // Frame bytes are left aligned with byte 0 in the top eight bits
   typedef struct packed {
      logic [2:0]  kind;
      logic [2:0]  nbytes;
      logic [39:0] frame;
      logic        exp_latch;
   } test_entry_t;

   logic clk;
   logic rst_n;
   logic spi_sclk;
   logic spi_cs_n;
   logic spi_mosi;
   logic spi_miso;
   logic drv_sclk;
   logic drv_lat;
   logic [2:0] drv_sin;
   logic [3:0] col_sel;

   test_entry_t test_tbl [6];
   logic [23:0] pix_model [1 << `POV_ADDR_W];
   logic [2:0][63:0] cap;
   logic [39:0] spi_rx;
   logic sclk_q = 1'b0;
   bit check_en = 1'b0;
   int hits [16];
   int hit_base [16];
   int nbits = 0;
   int latch_cnt = 0;
   int checked_cnt = 0;
   int wraps = 0;
   int skip = 0;
   int errors = 0;
   int last_col = 0;
   longint cyc = 0;
   longint last_lat_cyc = -1000;
   int rev0;
   int wrap0;
   int rev1;
   int wrap1;
   int diff;
   int seed_ret;
   int err_before;
   int pass_cnt;
   int fail_cnt;
   logic [23:0] new_px;

   pov_top i_pov_top (
      .clk      (clk),
      .rst_n    (rst_n),
      .spi_sclk (spi_sclk),
      .spi_cs_n (spi_cs_n),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso),
      .drv_sclk (drv_sclk),
      .drv_lat  (drv_lat),
      .drv_sin  (drv_sin),
      .col_sel  (col_sel)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Lane 0 red, 1 green, 2 blue; LED 0 first, MSB first
   function automatic logic [63:0] lane_bits(input int c, input int lane);
      logic [63:0] v;
      logic [23:0] px;
      v = '0;
      for (int led = 0; led < `POV_LEDS; led++) begin
         px = pix_model[c * `POV_LEDS + led];
         v  = {v[55:0], px[23 - 8*lane -: 8]};
      end
      return v;
   endfunction

   function automatic string test_name(input logic [2:0] kind);
      case (kind)
         K_IDLE:    return "idle after reset";
         K_FILL:    return "fill image and enable";
         K_REWRITE: return "rewrite one pixel";
         K_STATUS:  return "revolution count readback";
         K_DISABLE: return "display disable";
         default:   return "unknown opcode ignored";
      endcase
   endfunction

   // Mode 0 host at clk/10 that samples miso just before each rising sclk
   task automatic spi_frame(input logic [39:0] tx, input int n, output logic [39:0] rxb);
      logic [39:0] sh;
      sh  = tx;
      rxb = '0;
      @(posedge clk);
      spi_cs_n <= 1'b0;
      repeat (5) @(posedge clk);
      for (int i = 0; i < n * 8; i++) begin
         @(posedge clk);
         spi_sclk <= 1'b0;
         spi_mosi <= sh[39];
         sh = sh << 1;
         repeat (4) @(posedge clk);
         @(negedge clk);
         rxb = {rxb[38:0], spi_miso};
         @(posedge clk);
         spi_sclk <= 1'b1;
         repeat (4) @(posedge clk);
      end
      @(posedge clk);
      spi_sclk <= 1'b0;
      spi_mosi <= 1'b0;
      repeat (10) @(posedge clk);
      spi_cs_n <= 1'b1;
      repeat (10) @(posedge clk);
   endtask

   task automatic read_status(output int rev, output int w);
      w = wraps;
      spi_frame({8'h03, 32'h0}, 3, spi_rx);
      rev = spi_rx[15:0];
   endtask

   // Waits for a freshly checked latch of every column in the mask
   task automatic wait_columns(input logic [15:0] mask, input int limit);
      int n;
      bit done;
      for (int c = 0; c < 16; c++)
         hit_base[c] = hits[c];
      n    = 0;
      done = 1'b0;
      while (!done && n < limit) begin
         @(posedge clk);
         n++;
         done = 1'b1;
         for (int c = 0; c < 16; c++)
            if (mask[c] && hits[c] == hit_base[c])
               done = 1'b0;
      end
      if (!done) begin
         $display("Timeout: columns %h were not latched within %0d cycles", mask, limit);
         errors++;
      end
   endtask

   task automatic expect_no_latch(input int cycles);
      int snap;
      snap = latch_cnt;
      repeat (cycles) @(posedge clk);
      assert (latch_cnt == snap)
      else begin
         $display("[FAIL] drv_lat pulses: expected %h, got %h", 0, latch_cnt - snap);
         errors++;
      end
   endtask

   // Lane sampler on the falling clock edge where driver outputs are settled
   always @(negedge clk) begin : sample_blk
      logic [63:0] exp_lane;
      cyc++;
      if (drv_sclk && !sclk_q) begin
         for (int l = 0; l < 3; l++)
            cap[l] = {cap[l][62:0], drv_sin[l]};
         nbits++;
      end
      sclk_q = drv_sclk;
      if (drv_lat) begin
         if (check_en && skip > 0) begin
            skip--;
         end else if (check_en) begin
            for (int l = 0; l < 3; l++) begin
               exp_lane = lane_bits(col_sel, l);
               assert (cap[l] == exp_lane)
               else begin
                  $display("[FAIL] drv_sin[%0d] col %0d: expected %h, got %h",
                           l, col_sel, exp_lane, cap[l]);
                  errors++;
               end
            end
            assert (nbits == 64)
            else begin
               $display("[FAIL] drv_sclk rising edges: expected %h, got %h", 64, nbits);
               errors++;
            end
            // Back to back latches one period apart belong to adjacent columns
            if (last_lat_cyc == cyc - COL_PERIOD)
               assert (col_sel == 4'(last_col + 1))
               else begin
                  $display("[FAIL] col_sel: expected %h, got %h", 4'(last_col + 1), col_sel);
                  errors++;
               end
            hits[col_sel]++;
            checked_cnt++;
         end
         if (col_sel == 4'd0 && last_col == 15)
            wraps++;
         last_col     = col_sel;
         last_lat_cyc = cyc;
         latch_cnt++;
         nbits = 0;
      end
   end

   initial begin : main
      rst_n    = 1'b0;
      spi_sclk = 1'b0;
      spi_cs_n = 1'b1;
      spi_mosi = 1'b0;
      cap      = '0;
      pass_cnt = 0;
      fail_cnt = 0;
      seed_ret = $urandom(32'h6781_34c0);
      for (int c = 0; c < 16; c++)
         hits[c] = 0;

      test_tbl[0] = '{kind: K_IDLE, nbytes: 3'd0, frame: 40'h0, exp_latch: 1'b0};
      test_tbl[1] = '{kind: K_FILL, nbytes: 3'd2, frame: {16'h0201, 24'h0}, exp_latch: 1'b1};
      test_tbl[2] = '{kind: K_REWRITE, nbytes: 3'd5, frame: 40'h01_2b_c35a0f, exp_latch: 1'b1};
      test_tbl[3] = '{kind: K_STATUS, nbytes: 3'd3, frame: {8'h03, 32'h0}, exp_latch: 1'b1};
      test_tbl[4] = '{kind: K_DISABLE, nbytes: 3'd2, frame: {16'h0200, 24'h0}, exp_latch: 1'b0};
      test_tbl[5] = '{kind: K_UNKNOWN, nbytes: 3'd5, frame: 40'ha5_01_2b_00_00, exp_latch: 1'b0};

      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      for (int t = 0; t < 6; t++) begin
         err_before = errors;
         case (test_tbl[t].kind)
            K_IDLE: begin
               for (int n = 0; n < 4 * COL_PERIOD; n++) begin
                  @(negedge clk);
                  assert ({drv_lat, drv_sclk, drv_sin} == 5'd0)
                  else begin
                     $display("[FAIL] drv_lat/drv_sclk/drv_sin: expected %h, got %h",
                              5'd0, {drv_lat, drv_sclk, drv_sin});
                     errors++;
                     break;
                  end
               end
            end
            K_FILL: begin
               for (int a = 0; a < (1 << `POV_ADDR_W); a++) begin
                  new_px = $urandom;
                  pix_model[a] = new_px;
                  spi_frame({8'h01, 8'(a), new_px}, 5, spi_rx);
               end
               spi_frame(test_tbl[t].frame, test_tbl[t].nbytes, spi_rx);
               check_en = 1'b1;
               read_status(rev0, wrap0);
               wait_columns(16'hffff, 20 * COL_PERIOD);
            end
            K_REWRITE: begin
               // A column read before the write lands may still be in flight
               check_en = 1'b0;
               spi_frame(test_tbl[t].frame, test_tbl[t].nbytes, spi_rx);
               pix_model[test_tbl[t].frame[30:24]] = test_tbl[t].frame[23:0];
               skip     = 1;
               check_en = 1'b1;
               wait_columns(16'h1 << test_tbl[t].frame[30:27], 40 * COL_PERIOD);
            end
            K_STATUS: begin
               // Let at least three more revolutions pass before the second read
               for (int n = 0; n < 64 * COL_PERIOD && wraps - wrap0 < 3; n++)
                  @(posedge clk);
               if (wraps - wrap0 < 3) begin
                  $display("Timeout: fewer than three wraps seen within %0d cycles",
                           64 * COL_PERIOD);
                  errors++;
               end
               read_status(rev1, wrap1);
               diff = (rev1 - rev0) - (wrap1 - wrap0);
               assert (diff >= -1 && diff <= 1)
               else begin
                  $display("[FAIL] rev_count: expected %h (within one), got %h",
                           16'(rev0 + wrap1 - wrap0), 16'(rev1));
                  errors++;
               end
            end
            K_DISABLE: begin
               spi_frame(test_tbl[t].frame, test_tbl[t].nbytes, spi_rx);
               repeat (COL_PERIOD) @(posedge clk);
            end
            default: begin
               spi_frame(test_tbl[t].frame, test_tbl[t].nbytes, spi_rx);
            end
         endcase
         if (!test_tbl[t].exp_latch)
            expect_no_latch(3 * COL_PERIOD);
         // Display back on with all pixels as before the unknown frame
         if (test_tbl[t].kind == K_UNKNOWN) begin
            spi_frame({16'h0201, 24'h0}, 2, spi_rx);
            wait_columns(16'hffff, 20 * COL_PERIOD);
         end
         if (errors == err_before) begin
            pass_cnt++;
            $display("test %0d %s: ok", t, test_name(test_tbl[t].kind));
         end else begin
            fail_cnt++;
            $display("test %0d %s: %0d errors", t, test_name(test_tbl[t].kind),
                     errors - err_before);
         end
      end

      $display("tests %0d, passed %0d, failed %0d, latches checked %0d, errors %0d",
               pass_cnt + fail_cnt, pass_cnt, fail_cnt, checked_cnt, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

//--- build.f
+incdir+hw
hw/pov_pkg.sv
hw/spi_slave.sv
hw/spi_cmd_decoder.sv
hw/image_ram.sv
hw/column_scanner.sv
hw/led_driver_ctrl.sv
hw/rotation_emulator.sv
hw/pov_top.sv
verification/tb_pov_top.sv

//--- Bender.yml
package:
  name: pov_display

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/pov_pkg.sv
      - hw/spi_slave.sv
      - hw/spi_cmd_decoder.sv
      - hw/image_ram.sv
      - hw/column_scanner.sv
      - hw/led_driver_ctrl.sv
      - hw/rotation_emulator.sv
      - hw/pov_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verification/tb_pov_top.sv
